//--- design/dram_cfg_pkg.sv
package dram_cfg_pkg;

    // Word address is {bank, row, col}
    localparam int BANK_W    = 2;
    localparam int ROW_W     = 4;
    localparam int COL_W     = 4;
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = BANK_W + ROW_W + COL_W;
    localparam int ROW_LSB   = COL_W;
    localparam int BANK_LSB  = COL_W + ROW_W;
    localparam int NUM_BANKS = 1 << BANK_W;

    localparam int T_INIT = 20;
    localparam int T_ACT  = 3;
    localparam int T_WR   = 4;
    localparam int T_RD   = 4;
    localparam int T_PRE  = 3;
    localparam int T_REF  = 6;
    localparam int T_REFI = 200;

    localparam int DWELL_W = 4;                  // Wide enough for the longest dwell
    localparam int INIT_W  = $clog2(T_INIT);
    localparam int REFI_W  = $clog2(T_REFI);

    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- design/dram_cmd_pkg.sv
package dram_cmd_pkg;

    typedef enum logic [3:0] {
        POWER_UP,
        IDLE,
        ACTIVATE,
        ACTIVATING,
        WRITE,
        WRITING,
        READ,
        READING,
        PRECHARGE,
        REFRESH
    } cmd_state_t;

    typedef enum logic [1:0] {
        IDLE_R   = 2'b00,
        HIT      = 2'b01,
        MISS     = 2'b10,
        CONFLICT = 2'b11
    } row_stat_t;

    typedef enum logic [2:0] {
        NOP,
        ACT,
        WR,
        RD,
        PRE,
        REF
    } dram_cmd_t;

endpackage

//--- design/command_fsm.sv
module command_fsm (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       req_wr,
    input  logic                       req_rd,
    input  dram_cfg_pkg::addr_t        req_adr,
    input  dram_cmd_pkg::row_stat_t    row_stat,
    input  logic                       init_done,
    input  logic                       rf_req,
    input  logic                       t_act_done,
    input  logic                       t_wr_done,
    input  logic                       t_rd_done,
    input  logic                       t_pre_done,
    input  logic                       t_ref_done,
    output dram_cmd_pkg::cmd_state_t   cmd_state,
    output logic                       init_req,
    output logic                       row_resolve,
    output logic                       xfer_done,
    output dram_cmd_pkg::dram_cmd_t    dram_cmd,
    output dram_cfg_pkg::bank_t        dram_bank,
    output dram_cfg_pkg::row_t         dram_row,
    output dram_cfg_pkg::col_t         dram_col
);

    dram_cmd_pkg::cmd_state_t state_nxt;
    logic                     first_cyc;    // High on the first cycle spent in a state

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cmd_state <= dram_cmd_pkg::POWER_UP;
            first_cyc <= 1'b0;
        end else begin
            cmd_state <= state_nxt;
            first_cyc <= (state_nxt != cmd_state);
        end
    end

    always_comb begin
        state_nxt = cmd_state;
        case (cmd_state)
            dram_cmd_pkg::POWER_UP: begin
                if (init_done) state_nxt = dram_cmd_pkg::IDLE;
            end
            dram_cmd_pkg::IDLE: begin
                // Refresh always passes through PRECHARGE so every bank is closed at REF
                if (rf_req) begin
                    state_nxt = dram_cmd_pkg::PRECHARGE;
                end else if (req_wr || req_rd) begin
                    case (row_stat)
                        dram_cmd_pkg::HIT:
                            state_nxt = req_wr ? dram_cmd_pkg::WRITE : dram_cmd_pkg::READ;
                        dram_cmd_pkg::MISS:     state_nxt = dram_cmd_pkg::ACTIVATE;
                        dram_cmd_pkg::CONFLICT: state_nxt = dram_cmd_pkg::PRECHARGE;
                        default:                state_nxt = dram_cmd_pkg::IDLE;
                    endcase
                end
            end
            dram_cmd_pkg::ACTIVATE: state_nxt = dram_cmd_pkg::ACTIVATING;
            dram_cmd_pkg::ACTIVATING: begin
                if (t_act_done) begin
                    if (rf_req) state_nxt = dram_cmd_pkg::PRECHARGE;  // Access is retried later
                    else state_nxt = req_wr ? dram_cmd_pkg::WRITE : dram_cmd_pkg::READ;
                end
            end
            dram_cmd_pkg::WRITE: state_nxt = dram_cmd_pkg::WRITING;
            dram_cmd_pkg::READ:  state_nxt = dram_cmd_pkg::READING;
            dram_cmd_pkg::WRITING: begin
                if (t_wr_done) state_nxt = dram_cmd_pkg::IDLE;
            end
            dram_cmd_pkg::READING: begin
                if (t_rd_done) state_nxt = dram_cmd_pkg::IDLE;
            end
            dram_cmd_pkg::PRECHARGE: begin
                if (t_pre_done) state_nxt = rf_req ? dram_cmd_pkg::REFRESH : dram_cmd_pkg::IDLE;
            end
            dram_cmd_pkg::REFRESH: begin
                if (t_ref_done) state_nxt = dram_cmd_pkg::IDLE;
            end
            default: state_nxt = dram_cmd_pkg::IDLE;
        endcase
    end

    always_comb begin
        dram_cmd = dram_cmd_pkg::NOP;
        case (cmd_state)
            dram_cmd_pkg::ACTIVATE:  dram_cmd = dram_cmd_pkg::ACT;
            dram_cmd_pkg::WRITE:     dram_cmd = dram_cmd_pkg::WR;
            dram_cmd_pkg::READ:      dram_cmd = dram_cmd_pkg::RD;
            dram_cmd_pkg::PRECHARGE: if (first_cyc) dram_cmd = dram_cmd_pkg::PRE;
            dram_cmd_pkg::REFRESH:   if (first_cyc) dram_cmd = dram_cmd_pkg::REF;
            default:                 dram_cmd = dram_cmd_pkg::NOP;
        endcase
    end

    assign init_req    = (cmd_state == dram_cmd_pkg::POWER_UP);
    assign row_resolve = (cmd_state == dram_cmd_pkg::PRECHARGE);
    assign xfer_done   = ((cmd_state == dram_cmd_pkg::WRITING) && t_wr_done) ||
                         ((cmd_state == dram_cmd_pkg::READING) && t_rd_done);

    assign dram_bank = req_adr[dram_cfg_pkg::BANK_LSB +: dram_cfg_pkg::BANK_W];
    assign dram_row  = req_adr[dram_cfg_pkg::ROW_LSB +: dram_cfg_pkg::ROW_W];
    assign dram_col  = req_adr[dram_cfg_pkg::COL_W-1:0];

endmodule

//--- design/row_tracker.sv
module row_tracker (
    input  logic                    CLK,
    input  logic                    nRST,
    input  dram_cfg_pkg::addr_t     req_adr,
    input  dram_cmd_pkg::dram_cmd_t dram_cmd,
    input  logic                    row_resolve,
    output dram_cmd_pkg::row_stat_t row_stat
);

    logic [dram_cfg_pkg::NUM_BANKS-1:0] bank_open;
    dram_cfg_pkg::row_t                 open_row [dram_cfg_pkg::NUM_BANKS];
    dram_cfg_pkg::bank_t                req_bank;
    dram_cfg_pkg::row_t                 req_row;

    assign req_bank = req_adr[dram_cfg_pkg::BANK_LSB +: dram_cfg_pkg::BANK_W];
    assign req_row  = req_adr[dram_cfg_pkg::ROW_LSB +: dram_cfg_pkg::ROW_W];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bank_open <= '0;
        end else if (dram_cmd == dram_cmd_pkg::PRE) begin
            bank_open <= '0;                        // Precharge all
        end else if (dram_cmd == dram_cmd_pkg::ACT) begin
            bank_open[req_bank] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (dram_cmd == dram_cmd_pkg::ACT) open_row[req_bank] <= req_row;
    end

    // While banks are being closed the status is not meaningful
    always_comb begin
        if (row_resolve) row_stat = dram_cmd_pkg::IDLE_R;
        else if (!bank_open[req_bank]) row_stat = dram_cmd_pkg::MISS;
        else if (open_row[req_bank] == req_row) row_stat = dram_cmd_pkg::HIT;
        else row_stat = dram_cmd_pkg::CONFLICT;
    end

endmodule

//--- design/timing_ctrl.sv
module timing_ctrl (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dram_cmd_pkg::cmd_state_t cmd_state,
    input  logic                     init_req,
    output logic                     init_done,
    output logic                     rf_req,
    output logic                     t_act_done,
    output logic                     t_wr_done,
    output logic                     t_rd_done,
    output logic                     t_pre_done,
    output logic                     t_ref_done
);

    dram_cmd_pkg::cmd_state_t              prev_state;
    logic [dram_cfg_pkg::DWELL_W-1:0]      dwell_q;
    logic [dram_cfg_pkg::DWELL_W-1:0]      dwell;
    logic [dram_cfg_pkg::INIT_W-1:0]       init_cnt;
    logic [dram_cfg_pkg::REFI_W-1:0]       refi_cnt;

    assign dwell = (cmd_state != prev_state) ? '0 : dwell_q;   // Zero on the entry cycle

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_state <= dram_cmd_pkg::POWER_UP;
            dwell_q    <= '0;
        end else begin
            prev_state <= cmd_state;
            dwell_q    <= dwell + 1'b1;     // Wraps in IDLE, which has no dwell
        end
    end

    assign t_act_done = (cmd_state == dram_cmd_pkg::ACTIVATING) &&
                        (dwell == dram_cfg_pkg::DWELL_W'(dram_cfg_pkg::T_ACT - 1));
    assign t_wr_done  = (cmd_state == dram_cmd_pkg::WRITING) &&
                        (dwell == dram_cfg_pkg::DWELL_W'(dram_cfg_pkg::T_WR - 1));
    assign t_rd_done  = (cmd_state == dram_cmd_pkg::READING) &&
                        (dwell == dram_cfg_pkg::DWELL_W'(dram_cfg_pkg::T_RD - 1));
    assign t_pre_done = (cmd_state == dram_cmd_pkg::PRECHARGE) &&
                        (dwell == dram_cfg_pkg::DWELL_W'(dram_cfg_pkg::T_PRE - 1));
    assign t_ref_done = (cmd_state == dram_cmd_pkg::REFRESH) &&
                        (dwell == dram_cfg_pkg::DWELL_W'(dram_cfg_pkg::T_REF - 1));

    assign init_done = (init_cnt == dram_cfg_pkg::INIT_W'(dram_cfg_pkg::T_INIT - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) init_cnt <= '0;
        else if (init_req && !init_done) init_cnt <= init_cnt + 1'b1;
    end

    // Interval starts after init and restarts when a refresh ends
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refi_cnt <= '0;
            rf_req   <= 1'b0;
        end else if (cmd_state == dram_cmd_pkg::REFRESH || cmd_state == dram_cmd_pkg::POWER_UP) begin
            refi_cnt <= '0;
            rf_req   <= 1'b0;
        end else if (!rf_req) begin
            if (refi_cnt == dram_cfg_pkg::REFI_W'(dram_cfg_pkg::T_REFI - 1)) rf_req <= 1'b1;
            else refi_cnt <= refi_cnt + 1'b1;
        end
    end

endmodule

//--- design/wb_port.sv
module wb_port (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  dram_cfg_pkg::addr_t wb_adr,
    input  dram_cfg_pkg::data_t wb_dat_w,
    input  logic                xfer_done,
    input  dram_cfg_pkg::data_t dram_rdata,
    output dram_cfg_pkg::data_t wb_dat_r,
    output logic                wb_ack,
    output logic                req_wr,
    output logic                req_rd,
    output dram_cfg_pkg::addr_t req_adr,
    output dram_cfg_pkg::data_t dram_wdata
);

    logic accept;

    // The master still holds stb during ack, so that cycle must not start a new request
    assign accept = wb_cyc && wb_stb && !req_wr && !req_rd && !wb_ack;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_wr <= 1'b0;
            req_rd <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= xfer_done;
            if (xfer_done) begin
                req_wr <= 1'b0;
                req_rd <= 1'b0;
            end else if (accept) begin
                req_wr <= wb_we;
                req_rd <= !wb_we;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_adr    <= wb_adr;
            dram_wdata <= wb_dat_w;
        end
        if (xfer_done && req_rd) wb_dat_r <= dram_rdata;  // Model holds data since the RD
    end

endmodule

//--- design/dram_ctrl.sv
module dram_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  dram_cfg_pkg::addr_t     wb_adr,
    input  dram_cfg_pkg::data_t     wb_dat_w,
    output dram_cfg_pkg::data_t     wb_dat_r,
    output logic                    wb_ack,
    output dram_cmd_pkg::dram_cmd_t dram_cmd,
    output dram_cfg_pkg::bank_t     dram_bank,
    output dram_cfg_pkg::row_t      dram_row,
    output dram_cfg_pkg::col_t      dram_col,
    output dram_cfg_pkg::data_t     dram_wdata,
    input  dram_cfg_pkg::data_t     dram_rdata
);

    logic                     req_wr;
    logic                     req_rd;
    dram_cfg_pkg::addr_t      req_adr;
    logic                     xfer_done;
    dram_cmd_pkg::cmd_state_t cmd_state;
    logic                     init_req;
    logic                     row_resolve;
    dram_cmd_pkg::row_stat_t  row_stat;
    logic                     init_done;
    logic                     rf_req;
    logic                     t_act_done;
    logic                     t_wr_done;
    logic                     t_rd_done;
    logic                     t_pre_done;
    logic                     t_ref_done;

    wb_port u_wb_port (
        .CLK(CLK), .nRST(nRST),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .xfer_done(xfer_done), .dram_rdata(dram_rdata),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .req_wr(req_wr), .req_rd(req_rd),
        .req_adr(req_adr), .dram_wdata(dram_wdata)
    );

    command_fsm u_command_fsm (
        .CLK(CLK), .nRST(nRST),
        .req_wr(req_wr), .req_rd(req_rd), .req_adr(req_adr), .row_stat(row_stat),
        .init_done(init_done), .rf_req(rf_req), .t_act_done(t_act_done),
        .t_wr_done(t_wr_done), .t_rd_done(t_rd_done), .t_pre_done(t_pre_done),
        .t_ref_done(t_ref_done), .cmd_state(cmd_state), .init_req(init_req),
        .row_resolve(row_resolve), .xfer_done(xfer_done), .dram_cmd(dram_cmd),
        .dram_bank(dram_bank), .dram_row(dram_row), .dram_col(dram_col)
    );

    row_tracker u_row_tracker (
        .CLK(CLK), .nRST(nRST),
        .req_adr(req_adr), .dram_cmd(dram_cmd), .row_resolve(row_resolve),
        .row_stat(row_stat)
    );

    timing_ctrl u_timing_ctrl (
        .CLK(CLK), .nRST(nRST),
        .cmd_state(cmd_state), .init_req(init_req), .init_done(init_done),
        .rf_req(rf_req), .t_act_done(t_act_done), .t_wr_done(t_wr_done),
        .t_rd_done(t_rd_done), .t_pre_done(t_pre_done), .t_ref_done(t_ref_done)
    );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam real HALF_PERIOD = 4.0;      // 8 ns clock

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // Reset covers the first two rising edges and lifts right after the second
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

//--- verif/dram_ctrl_sva.sv
module dram_ctrl_sva (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_ack,
    input dram_cmd_pkg::dram_cmd_t  dram_cmd
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;
    int init_cyc;               // Cycles since reset, stops at T_INIT

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) init_cyc <= 0;
        else if (init_cyc < dram_cfg_pkg::T_INIT) init_cyc <= init_cyc + 1;
    end

    // Ack only answers a cycle that the master still holds
    a_ack_in_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_cnt++;
            $error("wb_ack high without wb_cyc and wb_stb");
        end

    a_ack_single: assert property (@(posedge CLK) disable iff (!nRST)
        wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("wb_ack high for two cycles in a row");
        end

    a_nop_in_init: assert property (@(posedge CLK) disable iff (!nRST)
        (init_cyc < dram_cfg_pkg::T_INIT) |-> (dram_cmd == dram_cmd_pkg::NOP && !wb_ack))
        else begin
            fail_cnt++;
            $error("DRAM command or ack issued during initialisation");
        end

endmodule

bind dram_ctrl dram_ctrl_sva u_sva (
    .CLK(CLK), .nRST(nRST), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .dram_cmd(dram_cmd)
);

//--- verif/tb_dram_ctrl.sv
module tb_dram_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_TIMEOUT = 500;
    localparam int MEM_WORDS   = 1 << dram_cfg_pkg::ADDR_W;

    logic                               CLK;
    logic                               nRST;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    dram_cfg_pkg::addr_t                wb_adr;
    dram_cfg_pkg::data_t                wb_dat_w;
    dram_cfg_pkg::data_t                wb_dat_r;
    logic                               wb_ack;
    dram_cmd_pkg::dram_cmd_t            dram_cmd;
    dram_cfg_pkg::bank_t                dram_bank;
    dram_cfg_pkg::row_t                 dram_row;
    dram_cfg_pkg::col_t                 dram_col;
    dram_cfg_pkg::data_t                dram_wdata;
    dram_cfg_pkg::data_t                dram_rdata = '0;

    dram_cfg_pkg::data_t                mem [MEM_WORDS];       // DRAM model contents
    dram_cfg_pkg::data_t                ref_mem [MEM_WORDS];   // What a read should return
    dram_cfg_pkg::addr_t                cmd_adr;
    logic [dram_cfg_pkg::NUM_BANKS-1:0] bank_open;
    dram_cfg_pkg::row_t                 bank_row [dram_cfg_pkg::NUM_BANKS];
    int                                 act_cnt;
    int                                 pre_cnt;
    int                                 ref_cnt;
    int                                 illegal_cnt;
    int                                 error_cnt;
    int                                 tests_failed;
    int                                 test_start;
    string                              cur_test;

    tb_clock u_clock (.CLK(CLK), .nRST(nRST));

    dram_ctrl u_dut (.*);

    function automatic dram_cfg_pkg::data_t fill_word(input int a);
        return {6'h2A, dram_cfg_pkg::addr_t'(a)};
    endfunction

    function automatic dram_cfg_pkg::addr_t make_adr(input dram_cfg_pkg::bank_t b,
                                                     input dram_cfg_pkg::row_t r,
                                                     input dram_cfg_pkg::col_t c);
        return {b, r, c};
    endfunction

    assign cmd_adr = {dram_bank, dram_row, dram_col};

    // Behavioural DRAM, one command per clock
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
            bank_open   = '0;
            act_cnt     = 0;
            pre_cnt     = 0;
            ref_cnt     = 0;
            illegal_cnt = 0;
        end else begin
            case (dram_cmd)
                dram_cmd_pkg::ACT: begin
                    assert (!bank_open[dram_bank]) else begin
                        $display("Illegal command: ACT to bank %0d while it is open", dram_bank);
                        illegal_cnt++;
                    end
                    bank_open[dram_bank] = 1'b1;
                    bank_row[dram_bank]  = dram_row;
                    act_cnt++;
                end
                dram_cmd_pkg::WR, dram_cmd_pkg::RD: begin
                    assert (bank_open[dram_bank] && bank_row[dram_bank] == dram_row) else begin
                        $display("Illegal command: %s to bank %0d row %0d, which is not open",
                                 dram_cmd.name(), dram_bank, dram_row);
                        illegal_cnt++;
                    end
                    if (dram_cmd == dram_cmd_pkg::WR) mem[cmd_adr] = dram_wdata;
                    else dram_rdata <= mem[cmd_adr];   // Held until the next RD
                end
                dram_cmd_pkg::PRE: begin
                    bank_open = '0;
                    pre_cnt++;
                end
                dram_cmd_pkg::REF: begin
                    assert (bank_open == '0) else begin
                        $display("Illegal command: REF while banks %b are open", bank_open);
                        illegal_cnt++;
                    end
                    ref_cnt++;
                end
                default: ;
            endcase
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    // One Wishbone classic cycle, entered and left 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input dram_cfg_pkg::addr_t adr,
                             input dram_cfg_pkg::data_t wdat, output dram_cfg_pkg::data_t rdat);
        int   waited;
        logic acked;
        waited   = 0;
        acked    = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        while (!acked && waited < ACK_TIMEOUT) begin
            @(posedge CLK);
            #1;
            waited++;
            acked = wb_ack;
        end
        assert (acked) else begin
            $display("%s: no ack within %0d cycles for the access to %h",
                     cur_test, ACK_TIMEOUT, adr);
            error_cnt++;
        end
        rdat = wb_dat_r;
        idle_cycles(1);                     // Stb stays up through the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic expect_data(input string what, input dram_cfg_pkg::data_t exp,
                               input dram_cfg_pkg::data_t act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            error_cnt++;
        end
    endtask

    task automatic expect_count(input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            error_cnt++;
        end
    endtask

    task automatic write_word(input dram_cfg_pkg::addr_t adr, input dram_cfg_pkg::data_t dat);
        dram_cfg_pkg::data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        ref_mem[adr] = dat;
    endtask

    task automatic check_read(input dram_cfg_pkg::addr_t adr, input dram_cfg_pkg::data_t exp);
        dram_cfg_pkg::data_t got;
        bus_cycle(1'b0, adr, '0, got);
        expect_data($sformatf("read of %h", adr), exp, got);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_start = error_cnt + illegal_cnt;
    endtask

    task automatic finish_test();
        int n;
        n = error_cnt + illegal_cnt - test_start;
        if (n == 0) begin
            $display("%-20s passed", cur_test);
        end else begin
            $display("%-20s failed with %0d errors", cur_test, n);
            tests_failed++;
        end
    endtask

    task automatic init_sequence();
        int waited;
        start_test("init_sequence");
        waited = 0;
        while (nRST !== 1'b1 && waited < 10) begin
            idle_cycles(1);
            waited++;
        end
        assert (nRST === 1'b1) else begin
            $display("%s: reset was not released within 10 cycles", cur_test);
            error_cnt++;
        end
        // The first write is already pending while the controller initialises
        fork
            write_word(make_adr(2'd0, 4'd1, 4'd3), 16'h1234);
            begin
                for (int i = 0; i < dram_cfg_pkg::T_INIT; i++) begin
                    assert (dram_cmd == dram_cmd_pkg::NOP && !wb_ack) else begin
                        $display("%s: command %s or an ack in cycle %0d of initialisation",
                                 cur_test, dram_cmd.name(), i);
                        error_cnt++;
                    end
                    idle_cycles(1);
                end
            end
        join
        check_read(make_adr(2'd0, 4'd1, 4'd3), 16'h1234);
        finish_test();
    endtask

    task automatic row_hit_access();
        int act_before;
        start_test("row_hit_access");
        act_before = act_cnt;
        write_word(make_adr(2'd1, 4'd5, 4'd7), 16'hC0DE);
        check_read(make_adr(2'd1, 4'd5, 4'd7), 16'hC0DE);
        expect_count("ACT commands", 1, act_cnt - act_before);
        finish_test();
    endtask

    task automatic row_conflict_access();
        int act_before;
        int pre_before;
        start_test("row_conflict_access");
        write_word(make_adr(2'd2, 4'd3, 4'd1), 16'hA5A5);
        act_before = act_cnt;
        pre_before = pre_cnt;
        write_word(make_adr(2'd2, 4'd9, 4'd1), 16'h5A5A);    // Same bank, other row
        expect_count("PRE commands", 1, pre_cnt - pre_before);
        expect_count("ACT commands", 1, act_cnt - act_before);
        check_read(make_adr(2'd2, 4'd3, 4'd1), 16'hA5A5);
        check_read(make_adr(2'd2, 4'd9, 4'd1), 16'h5A5A);
        finish_test();
    endtask

    task automatic random_traffic();
        dram_cfg_pkg::addr_t adr;
        start_test("random_traffic");
        for (int i = 0; i < 40; i++) begin
            adr = dram_cfg_pkg::addr_t'($urandom);
            if ($urandom_range(1) == 1) write_word(adr, dram_cfg_pkg::data_t'($urandom));
            else check_read(adr, ref_mem[adr]);
        end
        expect_count("illegal DRAM commands", 0, illegal_cnt);
        finish_test();
    endtask

    task automatic idle_refresh();
        int ref_before;
        start_test("idle_refresh");
        ref_before = ref_cnt;
        // Long enough for a full interval plus the precharge and refresh that follow it
        idle_cycles(dram_cfg_pkg::T_REFI + dram_cfg_pkg::T_PRE + dram_cfg_pkg::T_REF + 8);
        assert (ref_cnt > ref_before) else begin
            $display("%s: no REF command during the idle period", cur_test);
            error_cnt++;
        end
        expect_count("illegal DRAM commands", 0, illegal_cnt);
        check_read(make_adr(2'd0, 4'd1, 4'd3), ref_mem[make_adr(2'd0, 4'd1, 4'd3)]);
        check_read(make_adr(2'd1, 4'd5, 4'd7), ref_mem[make_adr(2'd1, 4'd5, 4'd7)]);
        check_read(make_adr(2'd2, 4'd9, 4'd1), ref_mem[make_adr(2'd2, 4'd9, 4'd1)]);
        finish_test();
    endtask

    initial begin
        void'($urandom(14));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = fill_word(i);
        init_sequence();
        row_hit_access();
        row_conflict_access();
        random_traffic();
        idle_refresh();
        $display("Tests run: 5, failed: %0d, errors: %0d, illegal DRAM commands: %0d, %s %0d",
                 tests_failed, error_cnt, illegal_cnt, "assertion failures:",
                 u_dut.u_sva.fail_cnt);
        if (error_cnt == 0 && illegal_cnt == 0 && u_dut.u_sva.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
design/dram_cfg_pkg.sv
design/dram_cmd_pkg.sv
design/command_fsm.sv
design/row_tracker.sv
design/timing_ctrl.sv
design/wb_port.sv
design/dram_ctrl.sv
verif/tb_clock.sv
verif/dram_ctrl_sva.sv
verif/tb_dram_ctrl.sv

//--- Makefile
SIM := obj_dir/Vtb_dram_ctrl

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

$(SIM): files.f $(wildcard design/*.sv verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_dram_ctrl -f files.f

clean:
	rm -rf obj_dir
